// File: filelist.f
verilog/data_source_pkg.sv
verilog/byte_buffer.sv
verilog/csr_regs.sv
verilog/command_engine.sv
verilog/data_source_top.sv
test/data_source_checker.sv
test/scoreboard.sv
test/tb_top.sv

// File: test/golden_ops.txt
# op addr byte, all hex; W write byte, R read and expect byte, X reserved op
# D dump whole buffer, C clear beat count, K check debug register; unused columns are 0
K 000 00
W 000 3c
W 001 a5
W fff 5a
W 7ff 81
W 123 e7
R 001 a5
R 000 3c
R fff 5a
W 001 17
R 001 17
R 123 e7
K 000 00
D 000 00
K 000 00
X 7ff 00
C 000 00
K 000 00
D 000 00
K 000 00
R 7ff 81

// File: test/tb_top.sv
module tb_top
  import data_source_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  logic        clk;
  logic        reset_n;
  reg_addr_e   avs_address;
  logic        avs_chipselect;
  logic        avs_write_n;
  logic [31:0] avs_writedata;
  logic [31:0] avs_readdata;
  logic [7:0]  axis_tdata;
  logic        axis_tvalid;
  logic        axis_tlast;
  logic        axis_tready;
  logic        chk;
  logic        gold_en;
  logic [7:0]  gold_byte;
  int          sb_errors;
  int          tb_errors;   // timeouts and file trouble
  logic [31:0] lcg_state;
  logic        dumping;     // tready follows the lcg while set

  data_source_top u_data_source_top (.*);

  scoreboard u_scoreboard (.*, .errors(sb_errors));

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] make_cmd(cmd_op_e op, logic [11:0] addr,
                                           logic [7:0] data, logic valid, logic clr);
    cmd_t c;
    c           = '0;
    c.valid     = valid;
    c.op        = op;
    c.addr      = addr;
    c.data      = data;
    c.clear_cnt = clr;
    return c;
  endfunction

  // all tasks start and end 2 ns after a rising edge
  task automatic write_ctrl(logic [31:0] word);
    avs_address    = reg_ctrl;
    avs_chipselect = 1'b1;
    avs_write_n    = 1'b0;
    avs_writedata  = word;
    @(posedge clk);
    #2;
    avs_chipselect = 1'b0;
    avs_write_n    = 1'b1;
  endtask

  task automatic poll(reg_addr_e addr, int bit_idx, logic want, int limit, string what);
    int   n;
    logic done;
    n    = 0;
    done = 1'b0;
    while (!done && n < limit) begin
      avs_address = addr;
      if (dumping) begin
        lcg_state   = lcg_next(lcg_state);
        axis_tready = lcg_state[16];
      end
      @(negedge clk);
      done = (avs_readdata[bit_idx] === want);
      @(posedge clk);
      #2;
      n++;
    end
    if (!done) begin
      tb_errors++;
      $display("timeout waiting for %s after %0d cycles", what, limit);
    end
  endtask

  task automatic check_reg(reg_addr_e addr, logic use_gold, logic [7:0] gold);
    avs_address = addr;
    chk         = 1'b1;
    gold_en     = use_gold;
    gold_byte   = gold;
    @(posedge clk);
    #2;
    chk     = 1'b0;
    gold_en = 1'b0;
  endtask

  task automatic run_cmd(logic [31:0] word, int limit, logic use_gold, logic [7:0] gold);
    write_ctrl(word);
    poll(reg_ctrl, 0, 1'b0, 50, "command accept");
    poll(reg_stat, 0, 1'b0, limit, "pending to fall");
    check_reg(reg_ctrl, 1'b0, 8'h00);
    check_reg(reg_stat, use_gold, gold);
  endtask

  initial begin : stimulus
    int          fd;
    int          n;
    string       line;
    byte         op_c;
    logic [11:0] a;
    logic [7:0]  d;
    reset_n        = 1'b0;
    avs_address    = reg_ctrl;
    avs_chipselect = 1'b0;
    avs_write_n    = 1'b1;
    avs_writedata  = '0;
    axis_tready    = 1'b0;
    chk            = 1'b0;
    gold_en        = 1'b0;
    gold_byte      = '0;
    tb_errors      = 0;
    dumping        = 1'b0;
    lcg_state      = 32'hde0d4883;
    repeat (3) @(posedge clk);
    #2;
    reset_n = 1'b1;
    check_reg(reg_ctrl, 1'b0, 8'h00);  // reset values
    check_reg(reg_stat, 1'b0, 8'h00);
    check_reg(reg_debug, 1'b0, 8'h00);
    check_reg(reg_rsvd, 1'b0, 8'h00);
    fd = $fopen("test/golden_ops.txt", "r");
    if (fd == 0) begin
      tb_errors++;
      $display("could not open test/golden_ops.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        if ($fgets(line, fd) != 0) begin
          n = $sscanf(line, "%c %h %h", op_c, a, d);
          if (n == 3 && op_c != "#") begin
            case (op_c)
              "W": run_cmd(make_cmd(op_write, a, d, 1'b1, 1'b0), 50, 1'b0, 8'h00);
              "R": run_cmd(make_cmd(op_read, a, 8'h00, 1'b1, 1'b0), 50, 1'b1, d);
              "X": run_cmd(make_cmd(op_rsvd, a, d, 1'b1, 1'b0), 50, 1'b0, 8'h00);
              "C": run_cmd(make_cmd(op_read, '0, 8'h00, 1'b0, 1'b1), 50, 1'b0, 8'h00);
              "K": check_reg(reg_debug, 1'b0, 8'h00);
              "D": begin
                dumping = 1'b1;
                run_cmd(make_cmd(op_dump, '0, 8'h00, 1'b1, 1'b0), 10000, 1'b0, 8'h00);
                dumping     = 1'b0;
                axis_tready = 1'b0;
              end
              default: begin
                tb_errors++;
                $display("unknown op letter %c in golden file", op_c);
              end
            endcase
          end
        end
      end
      $fclose(fd);
    end
    repeat (2) @(posedge clk);
    $display("errors: scoreboard %0d, testbench %0d, assertions %0d", sb_errors, tb_errors,
             u_data_source_top.u_command_engine.u_checker.fail_count);
    if (sb_errors == 0 && tb_errors == 0 &&
        u_data_source_top.u_command_engine.u_checker.fail_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: test/scoreboard.sv
module scoreboard
  import data_source_pkg::*;
(
  input  logic        clk,
  input  logic        reset_n,
  input  reg_addr_e   avs_address,
  input  logic        avs_chipselect,
  input  logic        avs_write_n,
  input  logic [31:0] avs_writedata,
  input  logic [31:0] avs_readdata,
  input  logic [7:0]  axis_tdata,
  input  logic        axis_tvalid,
  input  logic        axis_tlast,
  input  logic        axis_tready,
  input  logic        chk,        // compare the register on avs_address
  input  logic        gold_en,    // gold_byte applies to this check
  input  logic [7:0]  gold_byte,
  output int          errors
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [7:0]       model [buf_depth];
  logic             known [buf_depth];  // byte written since start
  logic [7:0]       rd_model;           // byte fetched by the last read command
  logic [cnt_w-1:0] beats;              // transfers since last clear
  int               dump_idx;
  logic             dump_open;
  logic             ctrl_written;

  task automatic compare(string name, logic [31:0] exp, logic [31:0] got);
    if (exp !== got) begin
      errors++;
      $display("mismatch %s exp %h got %h", name, exp, got);
    end
  endtask

  initial begin
    errors = 0;
    for (int i = 0; i < buf_depth; i++) begin
      known[i] = 1'b0;
    end
  end

  always @(posedge clk) begin : watch
    cmd_t   wr;
    stat_t  st;
    debug_t dbg;
    wr  = cmd_t'(avs_writedata);
    st  = stat_t'(avs_readdata);
    dbg = debug_t'(avs_readdata);
    if (!reset_n) begin
      beats        = '0;
      rd_model     = '0;
      dump_idx     = 0;
      dump_open    = 1'b0;
      ctrl_written = 1'b0;
    end else begin
      if (axis_tvalid && axis_tready) begin
        if (dump_idx < buf_depth && known[dump_idx]) begin
          compare("axis_tdata", model[dump_idx], axis_tdata);
        end
        compare("axis_tlast", dump_idx == buf_depth - 1, axis_tlast);
        dump_idx++;
        beats++;  // wraps like the hardware counter
      end
      if (chk) begin
        case (avs_address)
          reg_ctrl: begin
            if (ctrl_written) compare("ctrl.valid", 0, avs_readdata[0]);
            else compare("ctrl", 0, avs_readdata);
          end
          reg_stat: begin
            compare("stat.pending", 0, st.pending);
            compare("stat.rd_byte", rd_model, st.rd_byte);
            if (gold_en) compare("stat.rd_byte", gold_byte, st.rd_byte);
            if (dump_open) begin
              compare("dump beats", buf_depth, dump_idx);
              dump_open = 1'b0;
            end
          end
          reg_debug: begin
            compare("debug.count", beats, dbg.count);
            compare("debug.state", st_idle, dbg.state);
          end
          default: compare("rsvd", 0, avs_readdata);
        endcase
        compare("axis_tvalid", 0, axis_tvalid);  // engine idle at every check
      end
      if (avs_chipselect && !avs_write_n && avs_address == reg_ctrl) begin
        ctrl_written = 1'b1;
        if (wr.clear_cnt) beats = '0;
        if (wr.valid) begin
          case (wr.op)
            op_write: begin
              model[wr.addr] = wr.data;
              known[wr.addr] = 1'b1;
            end
            op_read: rd_model = model[wr.addr];
            op_dump: begin
              dump_idx  = 0;
              dump_open = 1'b1;
            end
            default: ;  // reserved, buffer untouched
          endcase
        end
      end
    end
  end

endmodule

// File: test/data_source_checker.sv
module data_source_checker
  import data_source_pkg::*;
(
  input logic                  clk,
  input logic                  reset_n,
  input cmd_t                  cmd,
  input logic                  cmd_accept,
  input stat_t                 stat,
  input logic [buf_addr_w-1:0] mem_addr,
  input axis_byte_t            stream,
  input logic                  axis_tready
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fail_count = 0;

  // the transfer at the last address ends the dump
  last_beat_ends_dump: assert property (@(posedge clk) disable iff (!reset_n)
    stream.tlast && axis_tready |=> !stream.tvalid)
    else begin
      fail_count++;
      $error("stream still valid after the last beat");
    end

  // stalled beat holds data, last flag and buffer address
  stall_holds: assert property (@(posedge clk) disable iff (!reset_n)
    stream.tvalid && !axis_tready |=> $stable(stream) && $stable(mem_addr))
    else begin
      fail_count++;
      $error("stream or address moved during a stall");
    end

  accept_pulse: assert property (@(posedge clk) disable iff (!reset_n)
    cmd_accept |=> !cmd_accept)
    else begin
      fail_count++;
      $error("cmd_accept held for more than one cycle");
    end

  // a host write would show up as a change of the control word
  quiet_while_pending: assert property (@(posedge clk) disable iff (!reset_n)
    stat.pending && $past(stat.pending) |-> $stable(cmd))
    else begin
      fail_count++;
      $error("control register written while a command was pending");
    end

endmodule

bind command_engine data_source_checker u_checker (
  .clk         (clk),
  .reset_n     (reset_n),
  .cmd         (cmd),
  .cmd_accept  (cmd_accept),
  .stat        (stat),
  .mem_addr    (mem_addr),
  .stream      (stream),
  .axis_tready (axis_tready)
);

// File: verilog/data_source_top.sv
module data_source_top
  import data_source_pkg::*;
(
  input  logic        clk,
  input  logic        reset_n,

  // avalon-mm register port
  input  reg_addr_e   avs_address,
  input  logic        avs_chipselect,
  input  logic        avs_write_n,
  input  logic [31:0] avs_writedata,
  output logic [31:0] avs_readdata,

  // axi4-stream byte output
  output logic [7:0]  axis_tdata,
  output logic        axis_tvalid,
  output logic        axis_tlast,
  input  logic        axis_tready
);

  cmd_t                  cmd;
  logic                  cmd_accept;
  stat_t                 stat;
  debug_t                debug;
  logic [buf_addr_w-1:0] mem_addr;
  logic [7:0]            mem_wdata;
  logic                  mem_we;
  logic [7:0]            mem_rdata;
  axis_byte_t            stream;

  csr_regs u_csr_regs (
    .clk            (clk),
    .reset_n        (reset_n),
    .avs_address    (avs_address),
    .avs_chipselect (avs_chipselect),
    .avs_write_n    (avs_write_n),
    .avs_writedata  (avs_writedata),
    .avs_readdata   (avs_readdata),
    .cmd_accept     (cmd_accept),
    .stat           (stat),
    .debug          (debug),
    .cmd            (cmd)
  );

  command_engine u_command_engine (
    .clk         (clk),
    .reset_n     (reset_n),
    .cmd         (cmd),
    .cmd_accept  (cmd_accept),
    .stat        (stat),
    .debug       (debug),
    .mem_addr    (mem_addr),
    .mem_wdata   (mem_wdata),
    .mem_we      (mem_we),
    .mem_rdata   (mem_rdata),
    .stream      (stream),
    .axis_tready (axis_tready)
  );

  byte_buffer u_byte_buffer (
    .clk       (clk),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_we    (mem_we),
    .mem_rdata (mem_rdata)
  );

  // stream struct out to the pins
  assign axis_tdata  = stream.tdata;
  assign axis_tvalid = stream.tvalid;
  assign axis_tlast  = stream.tlast;

endmodule

// File: verilog/command_engine.sv
module command_engine
  import data_source_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset_n,

  // from the register block
  input  cmd_t                  cmd,
  output logic                  cmd_accept,
  output stat_t                 stat,
  output debug_t                debug,

  // buffer port
  output logic [buf_addr_w-1:0] mem_addr,
  output logic [7:0]            mem_wdata,
  output logic                  mem_we,
  input  logic [7:0]            mem_rdata,

  // byte stream
  output axis_byte_t            stream,
  input  logic                  axis_tready
);

  engine_state_e         state_q;
  logic [buf_addr_w-1:0] addr_q;
  logic [7:0]            wdata_q;
  logic                  we_q;
  logic                  pending_q;
  logic [7:0]            rd_byte_q;
  logic                  tvalid_q;
  logic [cnt_w-1:0]      count_q;
  logic                  beat;      // stream transfer this cycle
  logic                  at_last;

  // first idle cycle with a valid command
  assign cmd_accept = (state_q == st_idle) && cmd.valid;

  assign beat    = tvalid_q && axis_tready;
  assign at_last = &addr_q;         // address 4095

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q   <= st_idle;
      addr_q    <= '0;
      we_q      <= 1'b0;
      pending_q <= 1'b0;
      rd_byte_q <= '0;
      tvalid_q  <= 1'b0;
    end else begin
      we_q <= 1'b0;                 // single cycle write strobe
      case (state_q)
        st_idle: begin
          if (cmd_accept) begin
            pending_q <= 1'b1;
            case (cmd.op)
              op_write: begin
                addr_q <= cmd.addr;
                we_q   <= 1'b1;
              end
              op_read: begin
                addr_q  <= cmd.addr;
                state_q <= st_read_wait;
              end
              op_dump: begin
                addr_q   <= '0;     // always from the bottom
                tvalid_q <= 1'b1;
                state_q  <= st_dump;
              end
              default: ;            // reserved op, pending just blips
            endcase
          end else begin
            // write and reserved ops retire here
            pending_q <= 1'b0;
          end
        end

        st_read_wait: begin
          // address has been on the buffer for a cycle
          rd_byte_q <= mem_rdata;
          pending_q <= 1'b0;
          state_q   <= st_idle;
        end

        st_dump: begin
          if (beat) begin
            if (at_last) begin
              tvalid_q  <= 1'b0;
              pending_q <= 1'b0;
              state_q   <= st_idle;
            end else begin
              addr_q <= addr_q + 1'b1;
            end
          end
        end

        default: begin
          state_q  <= st_idle;
          tvalid_q <= 1'b0;
        end
      endcase
    end
  end

  // write byte captured with the command
  always_ff @(posedge clk) begin
    if (cmd_accept) begin
      wdata_q <= cmd.data;
    end
  end

  // beat counter, wraps at 2^16
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      count_q <= '0;
    end else if (cmd.clear_cnt) begin
      count_q <= '0;
    end else if (beat) begin
      count_q <= count_q + 1'b1;
    end
  end

  assign mem_addr  = addr_q;
  assign mem_wdata = wdata_q;
  assign mem_we    = we_q;

  always_comb begin
    stat         = '0;
    stat.pending = pending_q;
    stat.rd_byte = rd_byte_q;

    debug       = '0;
    debug.count = count_q;
    debug.addr  = addr_q;
    debug.state = state_q;

    stream.tdata  = mem_rdata;            // byte at the current address
    stream.tvalid = tvalid_q;
    stream.tlast  = tvalid_q && at_last;  // final beat only
  end

endmodule

// File: verilog/csr_regs.sv
module csr_regs
  import data_source_pkg::*;
(
  input  logic        clk,
  input  logic        reset_n,

  // avalon-mm slave, no wait states
  input  reg_addr_e   avs_address,
  input  logic        avs_chipselect,
  input  logic        avs_write_n,
  input  logic [31:0] avs_writedata,
  output logic [31:0] avs_readdata,

  // engine side
  input  logic        cmd_accept,
  input  stat_t       stat,
  input  debug_t      debug,
  output cmd_t        cmd
);

  cmd_t ctrl_q;
  logic host_wr;      // any write strobe
  logic host_wr_ctrl; // write aimed at the control register

  assign host_wr      = avs_chipselect && !avs_write_n;
  assign host_wr_ctrl = host_wr && (avs_address == reg_ctrl);

  // control register
  // a host write replaces the whole word, otherwise the hardware
  // drops valid after accept and clear_cnt after one cycle
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      ctrl_q <= '0;
    end else if (host_wr_ctrl) begin
      ctrl_q <= cmd_t'(avs_writedata);
    end else begin
      if (cmd_accept) begin
        ctrl_q.valid <= 1'b0;     // engine took the command
      end
      if (ctrl_q.clear_cnt) begin
        ctrl_q.clear_cnt <= 1'b0; // one cycle clear pulse
      end
    end
  end

  assign cmd = ctrl_q;

  // readback mux, combinational from address
  always_comb begin
    case (avs_address)
      reg_ctrl:  avs_readdata = ctrl_q;
      reg_stat:  avs_readdata = stat;
      reg_rsvd:  avs_readdata = '0;     // old dma control slot
      reg_debug: avs_readdata = debug;
      default:   avs_readdata = '0;
    endcase
  end

endmodule

// File: verilog/byte_buffer.sv
module byte_buffer
  import data_source_pkg::*;
(
  input  logic                  clk,
  input  logic [buf_addr_w-1:0] mem_addr,
  input  logic [7:0]            mem_wdata,
  input  logic                  mem_we,
  output logic [7:0]            mem_rdata
);

  // plain array, contents undefined until written
  logic [7:0] mem [buf_depth];

  always_ff @(posedge clk) begin
    if (mem_we) begin
      mem[mem_addr] <= mem_wdata;
    end
  end

  // asynchronous read, the stream data path depends on it
  assign mem_rdata = mem[mem_addr];

endmodule

// File: verilog/data_source_pkg.sv
package data_source_pkg;

  // buffer geometry, fixed by the register map
  localparam int buf_addr_w = 12;
  localparam int buf_depth  = 4096;
  localparam int cnt_w      = 16;  // beat counter width

  // avalon register offsets
  typedef enum logic [1:0] {
    reg_ctrl  = 2'd0,
    reg_stat  = 2'd1,
    reg_rsvd  = 2'd2,
    reg_debug = 2'd3
  } reg_addr_e;

  typedef enum logic [1:0] {
    op_read  = 2'd0,
    op_write = 2'd1,
    op_dump  = 2'd2,
    op_rsvd  = 2'd3   // accepted, no action
  } cmd_op_e;

  typedef enum logic [1:0] {
    st_idle      = 2'd0,
    st_read_wait = 2'd1,
    st_dump      = 2'd2
  } engine_state_e;

  // control register layout
  typedef struct packed {
    logic                  clear_cnt;  // bit 31
    logic [6:0]            rsvd_hi;
    logic [7:0]            data;       // write byte
    logic [buf_addr_w-1:0] addr;
    logic                  rsvd_lo;
    cmd_op_e               op;
    logic                  valid;      // bit 0, command pending in register
  } cmd_t;

  typedef struct packed {
    logic [15:0] rsvd_hi;
    logic [7:0]  rd_byte;
    logic [6:0]  rsvd_lo;
    logic        pending;
  } stat_t;

  typedef struct packed {
    logic [1:0]            rsvd;
    engine_state_e         state;
    logic [buf_addr_w-1:0] addr;
    logic [cnt_w-1:0]      count;
  } debug_t;

  typedef struct packed {
    logic [7:0] tdata;
    logic       tvalid;
    logic       tlast;
  } axis_byte_t;

endpackage
